//--- logic/boot_loader_arb.sv
`timescale 1ns/100ps

module boot_loader_arb (
	input  logic                          clk_sys,
	input  logic                          rst_i,
	input  logic                          downloading_i,
	input  logic [glue_pkg::IDX_W-1:0]    dio_index_i,
	input  logic                          loader_we_i,
	input  glue_pkg::addr_t               loader_adr_i,
	input  glue_pkg::sel_t                loader_sel_i,
	input  glue_pkg::data_t               loader_dat_i,
	input  logic                          ram_ready_i,
	mem_bus_if.slave                      core,
	mem_bus_if.master                     ram,
	output logic                          core_reset_o
);

	logic            loader_active;
	logic            loader_active_q;
	logic            loader_stb;
	logic            rom_ready;
	glue_pkg::addr_t adr_mux;

	// only index 1 and 2 are ROM images
	assign loader_active = downloading_i &&
		(dio_index_i == glue_pkg::DIO_ROM_IDX_A || dio_index_i == glue_pkg::DIO_ROM_IDX_B);

	// loader strobe held from the write pulse until the ram acks
	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			loader_stb <= 1'b0;
		end else if (loader_we_i) begin
			loader_stb <= 1'b1;
		end else if (ram.ack) begin
			loader_stb <= 1'b0;
		end
	end

	// rom is ready once a ROM download has finished, sticky until reset
	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			loader_active_q <= 1'b0;
			rom_ready <= 1'b0;
		end else begin
			loader_active_q <= loader_active;
			if (loader_active_q && !loader_active) begin
				rom_ready <= 1'b1;
			end
		end
	end

	assign core_reset_o = !ram_ready_i || !rom_ready;

	// bus mux, loader wins while it downloads
	assign adr_mux = loader_active ? loader_adr_i : core.adr;

	assign ram.we = loader_active ? 1'b1 : core.we;
	assign ram.sel = loader_active ? loader_sel_i : core.sel;
	assign ram.adr = {adr_mux[glue_pkg::ADDR_W-1:2], 2'b00};
	assign ram.wdat = loader_active ? loader_dat_i : core.wdat;
	assign ram.stb = loader_active ? loader_stb : core.stb;
	assign ram.cyc = loader_active ? loader_stb : core.cyc;

	// core sees no ack while shut out
	assign core.ack = loader_active ? 1'b0 : ram.ack;

	// strobe must always sit inside a cycle, whichever side owns the bus
	a_stb_in_cyc : assert property (@(posedge clk_sys) disable iff (rst_i)
		ram.stb |-> ram.cyc)
	else $error("ram strobe high without cyc");

endmodule

//--- logic/glue_pkg.sv
package glue_pkg;

	// memory bus widths, byte address with word granularity
	localparam int ADDR_W = 24;
	localparam int DATA_W = 32;
	localparam int SEL_W = 4;

	// download index from the data loader
	localparam int IDX_W = 8;

	// bits per colour channel from the core
	localparam int COLOR_W = 4;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [SEL_W-1:0] sel_t;
	typedef logic [COLOR_W-1:0] color_t;

	// pixel base clock selection, TV mode when both bits are equal
	typedef enum logic [1:0] {
		VIDBASE_24     = 2'b00,
		VIDBASE_25     = 2'b01,
		VIDBASE_36     = 2'b10,
		VIDBASE_24_ALT = 2'b11
	} vidbase_t;

	typedef enum logic [1:0] {
		PLL_IDLE,
		PLL_ROM_WAIT,
		PLL_BUSY_WAIT,
		PLL_RUN
	} pll_state_t;

	// indices that count as a ROM load
	localparam logic [IDX_W-1:0] DIO_ROM_IDX_A = 8'd1;
	localparam logic [IDX_W-1:0] DIO_ROM_IDX_B = 8'd2;

	// back porch blanking length in clk_sys cycles
	localparam int PORCH_TV = 256;
	localparam int PORCH_VGA = 64;

endpackage

//--- logic/mem_bus_if.sv
`timescale 1ns/100ps

// word-wide memory bus, a transfer ends when ack is seen with stb high
interface mem_bus_if;

	logic              stb;
	logic              cyc;
	logic              we;
	glue_pkg::sel_t    sel;
	glue_pkg::addr_t   adr;
	glue_pkg::data_t   wdat;
	logic              ack;

	modport master (
		output stb,
		output cyc,
		output we,
		output sel,
		output adr,
		output wdat,
		input  ack
	);

	modport slave (
		input  stb,
		input  cyc,
		input  we,
		input  sel,
		input  adr,
		input  wdat,
		output ack
	);

endinterface

//--- logic/mist_glue_top.sv
`timescale 1ns/100ps

module mist_glue_top #(
	parameter int RECONFIG_TIMEOUT = 1000
) (
	input  logic                          clk_sys,
	input  logic                          rst_i,
	// core memory port
	input  logic                          core_stb_i,
	input  logic                          core_we_i,
	input  glue_pkg::sel_t                core_sel_i,
	input  glue_pkg::addr_t               core_adr_i,
	input  glue_pkg::data_t               core_dat_i,
	output logic                          core_ack_o,
	// ram port
	output logic                          ram_stb_o,
	output logic                          ram_cyc_o,
	output logic                          ram_we_o,
	output glue_pkg::sel_t                ram_sel_o,
	output glue_pkg::addr_t               ram_adr_o,
	output glue_pkg::data_t               ram_dat_o,
	input  logic                          ram_ack_i,
	// loader
	input  logic                          downloading_i,
	input  logic [glue_pkg::IDX_W-1:0]    dio_index_i,
	input  logic                          loader_we_i,
	input  glue_pkg::addr_t               loader_adr_i,
	input  glue_pkg::sel_t                loader_sel_i,
	input  glue_pkg::data_t               loader_dat_i,
	input  logic                          ram_ready_i,
	output logic                          core_reset_o,
	// pll reconfiguration
	input  glue_pkg::vidbase_t            pixbase_sel_i,
	input  logic                          pll_busy_i,
	output logic                          write_from_rom_o,
	output logic                          reconfig_o,
	output logic                          reconfig_reset_o,
	output glue_pkg::vidbase_t            rom_sel_o,
	// video
	input  logic                          ce_pix_i,
	input  logic                          scandoubler_disable_i,
	input  glue_pkg::color_t              core_r_i,
	input  glue_pkg::color_t              core_g_i,
	input  glue_pkg::color_t              core_b_i,
	input  logic                          core_hs_i,
	input  logic                          core_vs_i,
	output glue_pkg::color_t              vid_r_o,
	output glue_pkg::color_t              vid_g_o,
	output glue_pkg::color_t              vid_b_o,
	output logic                          vid_hs_o,
	output logic                          vid_vs_o,
	output logic                          scandoubler_en_o
);

	mem_bus_if core_bus ();
	mem_bus_if ram_bus ();

	// core has no separate cyc, its strobe covers both
	assign core_bus.stb = core_stb_i;
	assign core_bus.cyc = core_stb_i;
	assign core_bus.we = core_we_i;
	assign core_bus.sel = core_sel_i;
	assign core_bus.adr = core_adr_i;
	assign core_bus.wdat = core_dat_i;
	assign core_ack_o = core_bus.ack;

	assign ram_stb_o = ram_bus.stb;
	assign ram_cyc_o = ram_bus.cyc;
	assign ram_we_o = ram_bus.we;
	assign ram_sel_o = ram_bus.sel;
	assign ram_adr_o = ram_bus.adr;
	assign ram_dat_o = ram_bus.wdat;
	assign ram_bus.ack = ram_ack_i;

	boot_loader_arb u_arb (
		.clk_sys       (clk_sys),
		.rst_i         (rst_i),
		.downloading_i (downloading_i),
		.dio_index_i   (dio_index_i),
		.loader_we_i   (loader_we_i),
		.loader_adr_i  (loader_adr_i),
		.loader_sel_i  (loader_sel_i),
		.loader_dat_i  (loader_dat_i),
		.ram_ready_i   (ram_ready_i),
		.core          (core_bus.slave),
		.ram           (ram_bus.master),
		.core_reset_o  (core_reset_o)
	);

	pll_reconfig_seq #(
		.RECONFIG_TIMEOUT (RECONFIG_TIMEOUT)
	) u_pll_seq (
		.clk_sys          (clk_sys),
		.rst_i            (rst_i),
		.pixbase_sel_i    (pixbase_sel_i),
		.pll_busy_i       (pll_busy_i),
		.write_from_rom_o (write_from_rom_o),
		.reconfig_o       (reconfig_o),
		.reconfig_reset_o (reconfig_reset_o),
		.rom_sel_o        (rom_sel_o)
	);

	video_porch_blank u_blank (
		.clk_sys               (clk_sys),
		.rst_i                 (rst_i),
		.ce_pix_i              (ce_pix_i),
		.pixbase_sel_i         (pixbase_sel_i),
		.scandoubler_disable_i (scandoubler_disable_i),
		.core_r_i              (core_r_i),
		.core_g_i              (core_g_i),
		.core_b_i              (core_b_i),
		.core_hs_i             (core_hs_i),
		.core_vs_i             (core_vs_i),
		.vid_r_o               (vid_r_o),
		.vid_g_o               (vid_g_o),
		.vid_b_o               (vid_b_o),
		.vid_hs_o              (vid_hs_o),
		.vid_vs_o              (vid_vs_o),
		.scandoubler_en_o      (scandoubler_en_o)
	);

endmodule

//--- logic/pll_reconfig_seq.sv
`timescale 1ns/100ps

module pll_reconfig_seq #(
	parameter int RECONFIG_TIMEOUT = 1000
) (
	input  logic                clk_sys,
	input  logic                rst_i,
	input  glue_pkg::vidbase_t  pixbase_sel_i,
	input  logic                pll_busy_i,
	output logic                write_from_rom_o,
	output logic                reconfig_o,
	output logic                reconfig_reset_o,
	output glue_pkg::vidbase_t  rom_sel_o
);

	localparam int CNT_W = $clog2(RECONFIG_TIMEOUT + 1);

	glue_pkg::pll_state_t state;
	glue_pkg::vidbase_t   sel_in_q;
	glue_pkg::vidbase_t   sel_q;
	logic [CNT_W-1:0]     timeout_cnt;

	// input register runs always
	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			sel_in_q <= glue_pkg::VIDBASE_24;
		end else begin
			sel_in_q <= pixbase_sel_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			state <= glue_pkg::PLL_IDLE;
			sel_q <= glue_pkg::VIDBASE_24;
			timeout_cnt <= '0;
			write_from_rom_o <= 1'b0;
			reconfig_o <= 1'b0;
			reconfig_reset_o <= 1'b0;
		end else begin
			write_from_rom_o <= 1'b0;
			reconfig_o <= 1'b0;
			reconfig_reset_o <= 1'b0;
			case (state)
				glue_pkg::PLL_IDLE: begin
					// held selection only follows the input here
					sel_q <= sel_in_q;
					if (sel_q != sel_in_q) begin
						write_from_rom_o <= 1'b1;
						state <= glue_pkg::PLL_ROM_WAIT;
					end
				end
				glue_pkg::PLL_ROM_WAIT: begin
					state <= glue_pkg::PLL_BUSY_WAIT;
				end
				glue_pkg::PLL_BUSY_WAIT: begin
					if (!pll_busy_i) begin
						reconfig_o <= 1'b1;
						timeout_cnt <= CNT_W'(RECONFIG_TIMEOUT);
						state <= glue_pkg::PLL_RUN;
					end
				end
				glue_pkg::PLL_RUN: begin
					timeout_cnt <= timeout_cnt - CNT_W'(1);
					if (!reconfig_o && !pll_busy_i) begin
						state <= glue_pkg::PLL_IDLE;
					end else if (timeout_cnt == CNT_W'(1)) begin
						// engine stuck busy, kick it
						reconfig_reset_o <= 1'b1;
						state <= glue_pkg::PLL_IDLE;
					end
				end
				default: begin
					state <= glue_pkg::PLL_IDLE;
				end
			endcase
		end
	end

	assign rom_sel_o = sel_q;

	// the three engine commands never overlap
	a_one_cmd : assert property (@(posedge clk_sys) disable iff (rst_i)
		$onehot0({write_from_rom_o, reconfig_o, reconfig_reset_o}))
	else $error("more than one PLL command pulse at once");

endmodule

//--- logic/video_porch_blank.sv
`timescale 1ns/100ps

module video_porch_blank (
	input  logic                clk_sys,
	input  logic                rst_i,
	input  logic                ce_pix_i,
	input  glue_pkg::vidbase_t  pixbase_sel_i,
	input  logic                scandoubler_disable_i,
	input  glue_pkg::color_t    core_r_i,
	input  glue_pkg::color_t    core_g_i,
	input  glue_pkg::color_t    core_b_i,
	input  logic                core_hs_i,
	input  logic                core_vs_i,
	output glue_pkg::color_t    vid_r_o,
	output glue_pkg::color_t    vid_g_o,
	output glue_pkg::color_t    vid_b_o,
	output logic                vid_hs_o,
	output logic                vid_vs_o,
	output logic                scandoubler_en_o
);

	localparam int CNT_W = $clog2(glue_pkg::PORCH_TV + 1);

	logic             tv_mode;
	logic [CNT_W-1:0] porch_len;
	logic [CNT_W-1:0] pix_cnt;
	logic             porch_done;
	logic             show;

	assign tv_mode = pixbase_sel_i[1] == pixbase_sel_i[0];
	assign porch_len = tv_mode ? CNT_W'(glue_pkg::PORCH_TV) : CNT_W'(glue_pkg::PORCH_VGA);
	assign porch_done = pix_cnt == porch_len;
	assign show = porch_done && core_hs_i;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			pix_cnt <= '0;
			vid_hs_o <= 1'b0;
			vid_vs_o <= 1'b0;
			vid_r_o <= '0;
			vid_g_o <= '0;
			vid_b_o <= '0;
		end else begin
			// counts clk_sys cycles, restarts during sync
			if (!vid_hs_o) begin
				pix_cnt <= '0;
			end else if (!porch_done) begin
				pix_cnt <= pix_cnt + CNT_W'(1);
			end
			if (ce_pix_i) begin
				vid_hs_o <= core_hs_i;
				vid_vs_o <= core_vs_i;
				vid_r_o <= show ? core_r_i : '0;
				vid_g_o <= show ? core_g_i : '0;
				vid_b_o <= show ? core_b_i : '0;
			end
		end
	end

	assign scandoubler_en_o = tv_mode && !scandoubler_disable_i;

	a_black_in_sync : assert property (@(posedge clk_sys) disable iff (rst_i)
		!vid_hs_o |-> (vid_r_o == '0 && vid_g_o == '0 && vid_b_o == '0))
	else $error("colour not black during hsync");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	-f sources.f \
	--top-module tb_mist_glue \
	-Mdir "$BUILD_DIR" \
	-o tb_mist_glue
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_mist_glue" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation did not pass, see $LOG"
	exit 1
fi

//--- sim/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
	parameter int HALF_PERIOD = 2
) (
	output logic clk_sys,
	output logic rst_o
);

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	// reset spans two rising edges, released on a falling edge
	initial begin
		rst_o = 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_o = 1'b0;
	end

endmodule

//--- sim/tb_mist_glue.sv
`timescale 1ns/100ps

module tb_mist_glue;

	localparam int TIMEOUT = 20;
	localparam int CLK_PERIOD = 4;
	localparam int NUM_TESTS = 9;
	// the TV blanking run is the longest single test in cycles
	localparam int MAX_TEST_CYCLES = 2 * glue_pkg::PORCH_TV + 8 * TIMEOUT;
	// write comes two edges after the sampled selection change
	// reconfig comes two edges after the write
	localparam int WRITE_LAT = 2;
	localparam int RECONFIG_LAT = 2;

	typedef enum logic [2:0] {K_RESET, K_LOADER, K_PLL, K_TIMEOUT, K_BLANK} test_kind_t;

	typedef struct packed {
		test_kind_t         kind;
		glue_pkg::vidbase_t sel;
		logic               sd_dis;
		glue_pkg::addr_t    adr;
		glue_pkg::data_t    dat;
		glue_pkg::sel_t     bsel;
		int                 ack_delay;
		glue_pkg::addr_t    exp_adr;
		int                 exp_cycles;
		logic               exp_sd_en;
	} test_rec_t;

	logic clk_sys;
	logic rst_i;
	logic core_stb_i, core_we_i, core_ack_o;
	logic ram_stb_o, ram_cyc_o, ram_we_o, ram_ack_i;
	glue_pkg::sel_t core_sel_i, ram_sel_o, loader_sel_i;
	glue_pkg::addr_t core_adr_i, ram_adr_o, loader_adr_i;
	glue_pkg::data_t core_dat_i, ram_dat_o, loader_dat_i;
	logic downloading_i, loader_we_i, ram_ready_i, core_reset_o;
	logic [glue_pkg::IDX_W-1:0] dio_index_i;
	glue_pkg::vidbase_t pixbase_sel_i, rom_sel_o;
	logic pll_busy_i, write_from_rom_o, reconfig_o, reconfig_reset_o;
	logic ce_pix_i, scandoubler_disable_i, core_hs_i, core_vs_i;
	glue_pkg::color_t core_r_i, core_g_i, core_b_i, vid_r_o, vid_g_o, vid_b_o;
	logic vid_hs_o, vid_vs_o, scandoubler_en_o;

	test_rec_t tests [NUM_TESTS];
	int err_cnt;
	int pass_cnt;
	int fail_cnt;

	tb_clkgen u_clkgen (
		.clk_sys (clk_sys),
		.rst_o   (rst_i)
	);

	mist_glue_top #(
		.RECONFIG_TIMEOUT (TIMEOUT)
	) u_dut (.*);

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("error at %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_bus(input string what,
		input glue_pkg::addr_t got_adr, input glue_pkg::addr_t exp_adr,
		input glue_pkg::data_t got_dat, input glue_pkg::data_t exp_dat,
		input glue_pkg::sel_t got_sel, input glue_pkg::sel_t exp_sel);
		if (got_adr !== exp_adr || got_dat !== exp_dat || got_sel !== exp_sel) begin
			$display("error at %0t: %s adr %h dat %h sel %h, expected %h %h %h", $time, what,
				got_adr, got_dat, got_sel, exp_adr, exp_dat, exp_sel);
			err_cnt++;
		end
	endtask

	task automatic check_vid(input string what, input glue_pkg::color_t got,
		input glue_pkg::color_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_sel(input string what, input glue_pkg::vidbase_t got,
		input glue_pkg::vidbase_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
			err_cnt++;
		end
	endtask

	function automatic test_rec_t make_rec(input test_kind_t kind, input glue_pkg::vidbase_t sel,
		input logic sd_dis, input int exp_cycles, input logic exp_sd_en);
		test_rec_t r;
		logic [31:0] rnd;
		rnd = $urandom();
		r.kind = kind;
		r.sel = sel;
		r.sd_dis = sd_dis;
		r.adr = rnd[23:0];
		r.bsel = rnd[27:24];
		r.ack_delay = {30'd0, rnd[29:28]};
		r.dat = $urandom();
		// red channel never zero so the end of blanking is visible
		r.dat[0] = 1'b1;
		r.exp_adr = r.adr & {{(glue_pkg::ADDR_W-2){1'b1}}, 2'b00};
		r.exp_cycles = exp_cycles;
		r.exp_sd_en = exp_sd_en;
		return r;
	endfunction

	// counts falling edges until the chosen output is seen high
	task automatic count_until(input int which, input string name, input int bound,
		output int cycles);
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < bound) begin
			@(negedge clk_sys);
			cycles++;
			case (which)
				0: seen = write_from_rom_o;
				1: seen = reconfig_o;
				2: seen = reconfig_reset_o;
				default: seen = vid_hs_o;
			endcase
		end
		if (!seen) begin
			$display("%s never went high within %0d cycles", name, bound);
			err_cnt++;
		end
	endtask

	task automatic run_reset(input test_rec_t t);
		ram_ready_i = 1'b1;
		downloading_i = 1'b1;
		dio_index_i = 8'd3;
		repeat (4) begin
			@(negedge clk_sys);
			check_flag("core_reset_o in index 3 download", core_reset_o, 1'b1);
		end
		downloading_i = 1'b0;
		@(negedge clk_sys);
		check_flag("core_reset_o after index 3 download", core_reset_o, 1'b1);
		dio_index_i = glue_pkg::DIO_ROM_IDX_B;
		downloading_i = 1'b1;
		repeat (3) begin
			@(negedge clk_sys);
			check_flag("core_reset_o in ROM download", core_reset_o, 1'b1);
		end
		downloading_i = 1'b0;
		@(negedge clk_sys);
		check_flag("core_reset_o after ROM download", core_reset_o, 1'b0);
		// core owns the bus from here
		core_stb_i = 1'b1;
		core_we_i = 1'b1;
		core_adr_i = t.adr;
		core_dat_i = t.dat;
		core_sel_i = t.bsel;
		@(negedge clk_sys);
		check_flag("ram_stb_o from core", ram_stb_o, 1'b1);
		check_flag("ram_cyc_o from core", ram_cyc_o, 1'b1);
		check_flag("ram_we_o from core", ram_we_o, 1'b1);
		check_bus("core access", ram_adr_o, t.exp_adr, ram_dat_o, t.dat, ram_sel_o, t.bsel);
		ram_ack_i = 1'b1;
		@(negedge clk_sys);
		check_flag("core_ack_o", core_ack_o, 1'b1);
		ram_ack_i = 1'b0;
		core_stb_i = 1'b0;
		core_we_i = 1'b0;
	endtask

	task automatic run_loader(input test_rec_t t);
		downloading_i = 1'b1;
		dio_index_i = glue_pkg::DIO_ROM_IDX_A;
		loader_adr_i = t.adr;
		loader_dat_i = t.dat;
		loader_sel_i = t.bsel;
		loader_we_i = 1'b1;
		@(negedge clk_sys);
		loader_we_i = 1'b0;
		check_flag("ram_stb_o after loader write", ram_stb_o, 1'b1);
		check_flag("ram_cyc_o after loader write", ram_cyc_o, 1'b1);
		check_flag("ram_we_o in download", ram_we_o, 1'b1);
		check_bus("loader write", ram_adr_o, t.exp_adr, ram_dat_o, t.dat, ram_sel_o, t.bsel);
		repeat (t.ack_delay) begin
			@(negedge clk_sys);
			check_flag("ram_stb_o waiting for ack", ram_stb_o, 1'b1);
		end
		ram_ack_i = 1'b1;
		@(negedge clk_sys);
		check_flag("ram_stb_o after ack", ram_stb_o, 1'b0);
		check_flag("ram_cyc_o after ack", ram_cyc_o, 1'b0);
		check_flag("core_ack_o in download", core_ack_o, 1'b0);
		ram_ack_i = 1'b0;
	endtask

	task automatic run_pll(input test_rec_t t);
		int n;
		pixbase_sel_i = t.sel;
		count_until(0, "write_from_rom_o", 8, n);
		check_count("write_from_rom_o delay", n, WRITE_LAT);
		count_until(1, "reconfig_o", 8, n);
		check_count("reconfig_o after write", n, RECONFIG_LAT);
		check_sel("rom_sel_o", rom_sel_o, t.sel);
		// busy stays low so no kick and no new run
		repeat (2 * TIMEOUT) begin
			@(negedge clk_sys);
			check_flag("reconfig_reset_o with engine idle", reconfig_reset_o, 1'b0);
			check_flag("write_from_rom_o after run", write_from_rom_o, 1'b0);
		end
	endtask

	task automatic run_timeout(input test_rec_t t);
		int n;
		pixbase_sel_i = t.sel;
		count_until(0, "write_from_rom_o", 8, n);
		count_until(1, "reconfig_o", 8, n);
		pll_busy_i = 1'b1;
		@(negedge clk_sys);
		check_flag("reconfig_o pulse end", reconfig_o, 1'b0);
		count_until(2, "reconfig_reset_o", 2 * TIMEOUT, n);
		check_count("reconfig_reset_o after reconfig pulse", n, t.exp_cycles);
		@(negedge clk_sys);
		check_flag("reconfig_reset_o pulse end", reconfig_reset_o, 1'b0);
		pll_busy_i = 1'b0;
		check_sel("rom_sel_o", rom_sel_o, t.sel);
	endtask

	task automatic run_blank(input test_rec_t t);
		int n;
		int black;
		logic done;
		pixbase_sel_i = t.sel;
		scandoubler_disable_i = t.sd_dis;
		core_hs_i = 1'b0;
		// vsync flips with the hsync edge so both levels reach the output
		core_vs_i = 1'b1;
		core_r_i = t.dat[3:0];
		core_g_i = t.dat[7:4];
		core_b_i = t.dat[11:8];
		repeat (4) @(negedge clk_sys);
		check_flag("scandoubler_en_o", scandoubler_en_o, t.exp_sd_en);
		check_flag("vid_vs_o", vid_vs_o, 1'b1);
		core_hs_i = 1'b1;
		core_vs_i = 1'b0;
		count_until(3, "vid_hs_o", 8, n);
		check_count("vid_hs_o delay", n, 1);
		check_flag("vid_vs_o one enable later", vid_vs_o, 1'b0);
		black = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk_sys);
			if ({vid_r_o, vid_g_o, vid_b_o} != '0 || black > 2 * glue_pkg::PORCH_TV) begin
				done = 1'b1;
			end else begin
				black++;
			end
		end
		check_count("black after hsync", black, t.exp_cycles);
		check_vid("vid_r_o", vid_r_o, t.dat[3:0]);
		check_vid("vid_g_o", vid_g_o, t.dat[7:4]);
		check_vid("vid_b_o", vid_b_o, t.dat[11:8]);
		core_hs_i = 1'b0;
		@(negedge clk_sys);
		check_vid("vid_r_o in hsync", vid_r_o, '0);
	endtask

	initial begin
		int errs_before;
		test_kind_t kind;
		void'($urandom(32'h7d39));
		core_stb_i = 1'b0;
		core_we_i = 1'b0;
		core_sel_i = '0;
		core_adr_i = '0;
		core_dat_i = '0;
		ram_ack_i = 1'b0;
		downloading_i = 1'b0;
		dio_index_i = '0;
		loader_we_i = 1'b0;
		loader_adr_i = '0;
		loader_sel_i = '0;
		loader_dat_i = '0;
		ram_ready_i = 1'b0;
		pixbase_sel_i = glue_pkg::VIDBASE_24;
		pll_busy_i = 1'b0;
		ce_pix_i = 1'b1;
		scandoubler_disable_i = 1'b0;
		core_r_i = '0;
		core_g_i = '0;
		core_b_i = '0;
		core_hs_i = 1'b0;
		core_vs_i = 1'b0;
		err_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;

		// reset release goes first as rom_ready stays set until rst_i
		tests[0] = make_rec(K_RESET, glue_pkg::VIDBASE_24, 1'b0, 0, 1'b0);
		tests[1] = make_rec(K_LOADER, glue_pkg::VIDBASE_24, 1'b0, 0, 1'b0);
		tests[2] = make_rec(K_LOADER, glue_pkg::VIDBASE_24, 1'b0, 0, 1'b0);
		tests[3] = make_rec(K_LOADER, glue_pkg::VIDBASE_24, 1'b0, 0, 1'b0);
		tests[4] = make_rec(K_PLL, glue_pkg::VIDBASE_36, 1'b0, 0, 1'b0);
		tests[5] = make_rec(K_TIMEOUT, glue_pkg::VIDBASE_25, 1'b0, TIMEOUT - 1, 1'b0);
		tests[6] = make_rec(K_BLANK, glue_pkg::VIDBASE_24, 1'b0, glue_pkg::PORCH_TV, 1'b1);
		tests[7] = make_rec(K_BLANK, glue_pkg::VIDBASE_25, 1'b0, glue_pkg::PORCH_VGA, 1'b0);
		tests[8] = make_rec(K_BLANK, glue_pkg::VIDBASE_24_ALT, 1'b1, glue_pkg::PORCH_TV, 1'b0);

		@(negedge clk_sys);
		while (rst_i) @(negedge clk_sys);

		for (int i = 0; i < NUM_TESTS; i++) begin
			errs_before = err_cnt;
			kind = tests[i].kind;
			case (kind)
				K_RESET: run_reset(tests[i]);
				K_LOADER: run_loader(tests[i]);
				K_PLL: run_pll(tests[i]);
				K_TIMEOUT: run_timeout(tests[i]);
				default: run_blank(tests[i]);
			endcase
			if (err_cnt == errs_before) begin
				pass_cnt++;
				$display("test %0d %s passed", i, kind.name());
			end else begin
				fail_cnt++;
				$display("test %0d %s failed", i, kind.name());
			end
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS, pass_cnt, fail_cnt,
			err_cnt);
		if (fail_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// bound is every test at its longest plus the reset
	initial begin
		#(NUM_TESTS * MAX_TEST_CYCLES * CLK_PERIOD + 10 * CLK_PERIOD);
		$display("watchdog expired, the tests did not finish in time");
		$display("Something failed");
		$finish;
	end

endmodule

//--- sources.f
logic/glue_pkg.sv
logic/mem_bus_if.sv
logic/boot_loader_arb.sv
logic/pll_reconfig_seq.sv
logic/video_porch_blank.sv
logic/mist_glue_top.sv
sim/tb_clkgen.sv
sim/tb_mist_glue.sv
